// ==== Bender.yml ====
package:
  name: spi_flash_reader

sources:
  - files:
      - flash_pkg.sv
      - flash_cmd_shifter.sv
      - flash_rx_shifter.sv
      - flash_ctrl.sv
      - spi_flash_reader.sv
  - target: test
    files:
      - flash_ctrl_properties.sv
      - tb_spi_flash_reader.sv

// ==== flash_cmd_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module flash_cmd_shifter
	import flash_pkg::*;
(
	input wire logic i_clk,
	input wire logic i_load_read,
	input wire logic i_load_cfg,
	input wire logic [FLASH_AW-1:0] i_addr,
	input wire logic [7:0] i_byte,
	output logic o_mosi
);

	// Zero padding below a user byte
	localparam int CFG_PAD_W = CMD_PIPE_W - 9;

	// MSB goes out first
	logic [CMD_PIPE_W-1:0] pipe;

	always_ff @(posedge i_clk)
	begin
		// Idle bit, read command, byte address with word alignment
		if (i_load_read)
			pipe <= {1'b0, FLASH_READ_CMD, i_addr, 2'b00};
		// Idle bit and the user byte
		else if (i_load_cfg)
			pipe <= {1'b0, i_byte, {CFG_PAD_W{1'b0}}};
		// One bit per clock, zero fill
		else
			pipe <= {pipe[CMD_PIPE_W-2:0], 1'b0};
	end

	// First bit after a load is the idle zero
	assign o_mosi = pipe[CMD_PIPE_W-1];

endmodule

`default_nettype wire

// ==== flash_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module flash_ctrl
	import flash_pkg::*;
(
	input wire logic i_clk,
	input wire logic i_reset,
	input flash_bus_req_t i_req,
	output logic o_stall,
	output logic o_ack,
	output logic o_user_mode,
	output logic o_load_read,
	output logic o_load_cfg,
	output logic o_spi_cs_n,
	output logic o_spi_sck
);

	//////////////////////////////////////////////////////////////////////
	// Request decode
	//////////////////////////////////////////////////////////////////////

	logic accept_mem;
	logic accept_cfg;
	logic read_start;
	logic cfg_write;
	logic cfg_start;
	logic imm_ack;

	xfer_cnt_t xfer_cnt;
	logic cnt_last;
	logic cnt_more;

	// Clock running, also bus busy
	logic busy;
	logic ack_q;
	logic user_mode;
	logic cs_n;

	// A request is taken only while not stalled
	assign accept_mem = i_req.stb && !busy;
	assign accept_cfg = i_req.cfg_stb && !busy;

	// Memory read, only outside user mode
	assign read_start = accept_mem && !i_req.we && !user_mode;

	// Any configuration write updates user mode
	assign cfg_write = accept_cfg && i_req.we;
	// CS bit clear means exchange one byte
	assign cfg_start = cfg_write && !i_req.wdata[CFG_CS_BIT];

	// Everything else is answered on the next cycle
	assign imm_ack = (accept_mem || accept_cfg) && !read_start && !cfg_start;

	assign cnt_last = (xfer_cnt == xfer_cnt_t'(1));
	assign cnt_more = (xfer_cnt > xfer_cnt_t'(1));

	//////////////////////////////////////////////////////////////////////
	// Transfer counter
	//////////////////////////////////////////////////////////////////////

	// Cycles left until the ack, zero when idle
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			xfer_cnt <= '0;
		else if (read_start)
			xfer_cnt <= READ_CYCLES;
		else if (cfg_start)
			xfer_cnt <= CFG_CYCLES;
		else if (xfer_cnt != '0)
			xfer_cnt <= xfer_cnt - xfer_cnt_t'(1);
	end

	// Serial clock and stall share one register
	// High from the cycle after the start until the counter reaches one
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			busy <= 1'b0;
		else if (read_start || cfg_start)
			busy <= 1'b1;
		else
			busy <= cnt_more;
	end

	// End of a transfer or an immediate answer
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			ack_q <= 1'b0;
		else if (cnt_last)
			ack_q <= 1'b1;
		else
			ack_q <= imm_ack;
	end

	//////////////////////////////////////////////////////////////////////
	// User mode and chip select
	//////////////////////////////////////////////////////////////////////

	// Set by a byte write, cleared by a write with the CS bit set
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			user_mode <= 1'b0;
		else if (cfg_write)
			user_mode <= !i_req.wdata[CFG_CS_BIT];
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			cs_n <= 1'b1;
		else if (read_start)
			cs_n <= 1'b0;
		else if (cfg_write)
			cs_n <= i_req.wdata[CFG_CS_BIT];
		// Held low between user bytes
		else if (user_mode)
			cs_n <= 1'b0;
		// Memory read done, release with the ack
		else if (cnt_last)
			cs_n <= 1'b1;
	end

	// Outputs
	assign o_stall = busy;
	assign o_spi_sck = busy;
	assign o_ack = ack_q;
	assign o_user_mode = user_mode;
	assign o_spi_cs_n = cs_n;

	// One-cycle loads for the command shifter
	assign o_load_read = read_start;
	assign o_load_cfg = cfg_start;

endmodule

`default_nettype wire

// ==== flash_ctrl_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module flash_ctrl_properties
	import flash_pkg::*;
(
	input wire logic i_clk,
	input wire logic i_reset,
	input wire flash_bus_req_t i_req,
	input wire logic i_stall,
	input wire logic i_ack,
	input wire logic i_user_mode,
	input wire logic i_cs_n,
	input wire logic i_sck
);

	// Count of failed assertions
	int fail_count = 0;

	// Request taken at the coming edge
	logic req_taken;
	assign req_taken = (i_req.stb || i_req.cfg_stb) && !i_stall;

	//////////////////////////////////////////////////////////////////////
	// Pin and handshake rules
	//////////////////////////////////////////////////////////////////////

	// No serial clock while the flash is deselected
	sck_inside_cs: assert property (@(posedge i_clk) disable iff (i_reset)
		i_cs_n |-> !i_sck)
	else
	begin
		$error("serial clock high while chip select is released");
		fail_count++;
	end

	// Reset leaves every control output idle
	idle_after_reset: assert property (@(posedge i_clk)
		i_reset |=> (i_cs_n && !i_sck && !i_stall && !i_ack && !i_user_mode))
	else
	begin
		$error("control outputs not idle after reset");
		fail_count++;
	end

	// A second ack cycle only for a newly taken request
	ack_single: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_ack && !req_taken) |=> !i_ack)
	else
	begin
		$error("ack held for more than one cycle");
		fail_count++;
	end

endmodule

bind flash_ctrl flash_ctrl_properties props_i (
	.i_clk(i_clk),
	.i_reset(i_reset),
	.i_req(i_req),
	.i_stall(o_stall),
	.i_ack(o_ack),
	.i_user_mode(o_user_mode),
	.i_cs_n(o_spi_cs_n),
	.i_sck(o_spi_sck)
);

`default_nettype wire

// ==== flash_pkg.sv ====
`default_nettype none

package flash_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus and protocol constants
	//////////////////////////////////////////////////////////////////////

	// Bus word address, byte address is this plus two zero bits
	localparam int FLASH_AW = 22;
	localparam int BUS_DW = 32;

	// Serial read command, sent MSB first
	localparam logic [7:0] FLASH_READ_CMD = 8'h03;

	// Idle bit, command byte, 24-bit byte address
	localparam int CMD_PIPE_W = 33;

	// Configuration data bit that gives the chip select level
	localparam int CFG_CS_BIT = 8;
	// Marker bit in read data while in user mode
	localparam int USER_FLAG_BIT = 12;

	// Cycles remaining in a transfer
	typedef logic [6:0] xfer_cnt_t;

	// Idle + command + address + 32 data bits
	localparam xfer_cnt_t READ_CYCLES = 7'd65;
	// Idle + one user byte
	localparam xfer_cnt_t CFG_CYCLES = 7'd9;

	//////////////////////////////////////////////////////////////////////
	// Bundled signals
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic stb;
		logic cfg_stb;
		logic we;
		logic [FLASH_AW-1:0] addr;
		logic [BUS_DW-1:0] wdata;
	} flash_bus_req_t;

	typedef struct packed {
		logic stall;
		logic ack;
		logic [BUS_DW-1:0] rdata;
	} flash_bus_rsp_t;

	// Chip select is active low
	typedef struct packed {
		logic cs_n;
		logic sck;
		logic mosi;
	} spi_pins_t;

endpackage

`default_nettype wire

// ==== flash_rx_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module flash_rx_shifter
	import flash_pkg::*;
(
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_sck,
	input wire logic i_user_mode,
	input wire logic i_miso,
	output logic [BUS_DW-1:0] o_rdata
);

	// Serial clock as seen by the flash, one cycle late
	logic sck_d;
	// MSB first, newest bit at the bottom
	logic [BUS_DW-1:0] shreg;
	// Config port view of the shift register
	logic [BUS_DW-1:0] user_word;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			sck_d <= 1'b0;
		else
			sck_d <= i_sck;
	end

	// One MISO bit per delayed clock
	always_ff @(posedge i_clk)
	begin
		if (sck_d)
			shreg <= {shreg[BUS_DW-2:0], i_miso};
	end

	// User mode shows the last byte plus the marker bit
	always_comb
	begin
		user_word = '0;
		user_word[7:0] = shreg[7:0];
		user_word[USER_FLAG_BIT] = 1'b1;
	end

	assign o_rdata = i_user_mode ? user_word : shreg;

endmodule

`default_nettype wire

// ==== spi_flash_reader.f ====
flash_pkg.sv
flash_cmd_shifter.sv
flash_rx_shifter.sv
flash_ctrl.sv
spi_flash_reader.sv
flash_ctrl_properties.sv
tb_spi_flash_reader.sv

// ==== spi_flash_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_flash_reader
	import flash_pkg::*;
(
	input wire logic i_clk,
	input wire logic i_reset,
	input flash_bus_req_t i_bus,
	output flash_bus_rsp_t o_bus,
	output spi_pins_t o_spi,
	input wire logic i_spi_miso
);

	// Control to datapath
	logic stall;
	logic ack;
	logic user_mode;
	logic load_read;
	logic load_cfg;
	logic spi_cs_n;
	logic spi_sck;
	logic spi_mosi;
	logic [BUS_DW-1:0] rdata;

	// Counter, chip select, clock and handshake
	flash_ctrl ctrl_i (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_req(i_bus),
		.o_stall(stall),
		.o_ack(ack),
		.o_user_mode(user_mode),
		.o_load_read(load_read),
		.o_load_cfg(load_cfg),
		.o_spi_cs_n(spi_cs_n),
		.o_spi_sck(spi_sck)
	);

	// Outgoing command, address or user byte
	flash_cmd_shifter cmd_i (
		.i_clk(i_clk),
		.i_load_read(load_read),
		.i_load_cfg(load_cfg),
		.i_addr(i_bus.addr),
		.i_byte(i_bus.wdata[7:0]),
		.o_mosi(spi_mosi)
	);

	// Incoming flash data
	flash_rx_shifter rx_i (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_sck(spi_sck),
		.i_user_mode(user_mode),
		.i_miso(i_spi_miso),
		.o_rdata(rdata)
	);

	// Bus response
	assign o_bus.stall = stall;
	assign o_bus.ack = ack;
	assign o_bus.rdata = rdata;

	// Flash pins
	assign o_spi.cs_n = spi_cs_n;
	assign o_spi.sck = spi_sck;
	assign o_spi.mosi = spi_mosi;

endmodule

`default_nettype wire

// ==== tb_spi_flash_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spi_flash_reader
	import flash_pkg::*;
();

	// Bus requests in all tests set the watchdog time
	localparam int N_TXNS = 45;
	localparam int WATCHDOG_NS = (N_TXNS * 80 + 100) * 4;
	localparam int ACK_LIMIT = 200;

	logic clk = 1'b0;
	logic reset = 1'b1;
	flash_bus_req_t bus_req = '0;
	flash_bus_rsp_t bus_rsp;
	spi_pins_t spi;
	logic spi_miso = 1'b0;

	integer seed = 54;
	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// Flash contents and the answer byte for the next user transfer
	logic [BUS_DW-1:0] mem [0:255];
	logic [7:0] user_answer = '0;

	// Flash model state
	int bit_k = 0;
	logic prev_sck = 1'b0;
	logic miso_next = 1'b0;
	logic [64:0] frame_sr = '0;
	int frame_len = 0;
	logic [FLASH_AW-1:0] cap_addr;
	logic [BUS_DW-1:0] cap_word;

	// Seen during the last bus request
	int lat;
	int sck_cycles;
	int stall_cycles;
	logic cs_high_seen;
	logic cs_low_seen;
	logic [BUS_DW-1:0] rdata;

	spi_flash_reader dut_i (
		.i_clk(clk),
		.i_reset(reset),
		.i_bus(bus_req),
		.o_bus(bus_rsp),
		.o_spi(spi),
		.i_spi_miso(spi_miso)
	);

	always #2 clk = ~clk;

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("Test failures found");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Flash model
	//////////////////////////////////////////////////////////////////////

	// Stored word mixed with the whole address
	function automatic logic [BUS_DW-1:0] flash_word(input logic [FLASH_AW-1:0] a);
		return mem[a[7:0]] ^ {10'd0, a};
	endfunction

	// Captures MOSI per clock-high cycle and answers one cycle later
	always @(posedge clk)
	begin
		#1;
		spi_miso = miso_next;
		miso_next = 1'b0;
		if (spi.sck && !spi.cs_n)
		begin
			// New burst of clock cycles starts a new frame
			if (!prev_sck)
				bit_k = 0;
			frame_sr = {frame_sr[63:0], spi.mosi};
			frame_len = bit_k + 1;
			// User byte answer goes MSB first
			if (bit_k >= 1 && bit_k <= 8)
				miso_next = user_answer[8 - bit_k];
			// Last address bit just captured
			if (bit_k == 32)
			begin
				cap_addr = frame_sr[23:2];
				cap_word = flash_word(cap_addr);
			end
			if (bit_k >= 32 && bit_k <= 63)
				miso_next = cap_word[63 - bit_k];
			bit_k++;
		end
		prev_sck = spi.sck;
	end

	//////////////////////////////////////////////////////////////////////
	// Bus driver and checks
	//////////////////////////////////////////////////////////////////////

	// Config read data in user mode
	function automatic logic [BUS_DW-1:0] user_word(input logic [7:0] b);
		logic [BUS_DW-1:0] w;
		w = '0;
		w[USER_FLAG_BIT] = 1'b1;
		w[7:0] = b;
		return w;
	endfunction

	task automatic value_error(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		$display("ERR %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
		errors++;
		test_errors++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("Test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAILED",
			test_errors);
		test_errors = 0;
	endtask

	task automatic observe_pins();
		sck_cycles += spi.sck;
		stall_cycles += bus_rsp.stall;
		if (spi.cs_n)
			cs_high_seen = 1'b1;
		else
			cs_low_seen = 1'b1;
	endtask

	// One request after a random gap and the wait for its ack
	task automatic bus_request(input logic stb, input logic cfg_stb, input logic we,
		input logic [FLASH_AW-1:0] addr, input logic [BUS_DW-1:0] wdata);
		int gap;
		gap = {$random(seed)} % 3;
		sck_cycles = 0;
		stall_cycles = 0;
		cs_high_seen = 1'b0;
		cs_low_seen = 1'b0;
		observe_pins();
		repeat (gap)
		begin
			@(posedge clk);
			#1;
			observe_pins();
		end
		bus_req.stb = stb;
		bus_req.cfg_stb = cfg_stb;
		bus_req.we = we;
		bus_req.addr = addr;
		bus_req.wdata = wdata;
		lat = 0;
		do
		begin
			@(posedge clk);
			#1;
			// Stall was low, so the first edge took it
			bus_req.stb = 1'b0;
			bus_req.cfg_stb = 1'b0;
			lat++;
			observe_pins();
		end while (!bus_rsp.ack && lat < ACK_LIMIT);
		rdata = bus_rsp.rdata;
		if (!bus_rsp.ack)
		begin
			$display("A bus request got no ack within %0d cycles", ACK_LIMIT);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_mem_read(input logic [FLASH_AW-1:0] addr);
		logic [32:0] exp_head;
		exp_head = {1'b0, 8'h03, addr, 2'b00};
		bus_request(1'b1, 1'b0, 1'b0, addr, '0);
		if (lat != 66)
			value_error("read ack latency", lat, 66);
		if (rdata !== flash_word(addr))
			value_error("read data", rdata, flash_word(addr));
		if (sck_cycles != 65 || frame_len != 65)
			value_error("read clock cycles", sck_cycles, 65);
		if (stall_cycles != 65)
			value_error("read stall cycles", stall_cycles, 65);
		if (frame_sr[64:32] !== exp_head)
			value_error("read command and address on MOSI", frame_sr[64:32], exp_head);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [FLASH_AW-1:0] addr;
		logic [7:0] b;
		for (int i = 0; i < 256; i++)
			mem[i] = $random(seed);
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		if (spi.cs_n !== 1'b1 || spi.sck !== 1'b0 || bus_rsp.stall !== 1'b0 ||
			bus_rsp.ack !== 1'b0)
			value_error("cs_n, sck, stall, ack after reset",
				{spi.cs_n, spi.sck, bus_rsp.stall, bus_rsp.ack}, 4'b1000);
		finish_test("reset_state");

		repeat (16)
		begin
			addr = $random(seed);
			check_mem_read(addr);
		end
		finish_test("mem_read");

		// Writes to memory are answered at once
		repeat (8)
		begin
			addr = $random(seed);
			bus_request(1'b1, 1'b0, 1'b1, addr, $random(seed));
			if (lat != 1)
				value_error("write ack latency", lat, 1);
			if (sck_cycles != 0 || cs_low_seen)
				value_error("serial activity during write", sck_cycles, 0);
			if (stall_cycles != 0)
				value_error("write stall cycles", stall_cycles, 0);
		end
		finish_test("mem_write");

		// Byte out and answer read back while CS stays low
		repeat (4)
		begin
			b = $random(seed);
			user_answer = $random(seed);
			bus_request(1'b0, 1'b1, 1'b1, '0, {24'd0, b});
			if (lat != 10)
				value_error("user byte ack latency", lat, 10);
			if (sck_cycles != 9 || frame_len != 9)
				value_error("user byte clock cycles", sck_cycles, 9);
			if (stall_cycles != 9)
				value_error("user byte stall cycles", stall_cycles, 9);
			if (frame_sr[8:0] !== {1'b0, b})
				value_error("user byte on MOSI", frame_sr[8:0], {1'b0, b});
			bus_request(1'b0, 1'b1, 1'b0, '0, '0);
			if (lat != 1)
				value_error("config read ack latency", lat, 1);
			if (rdata !== user_word(user_answer))
				value_error("config read data", rdata, user_word(user_answer));
			if (cs_high_seen)
				value_error("chip select between user bytes", 1, 0);
		end
		finish_test("user_byte");

		repeat (4)
		begin
			addr = $random(seed);
			bus_request(1'b1, 1'b0, 1'b0, addr, '0);
			if (lat != 1)
				value_error("user mode read ack latency", lat, 1);
			if (sck_cycles != 0)
				value_error("user mode read clock cycles", sck_cycles, 0);
			if (rdata !== user_word(user_answer))
				value_error("user mode read data", rdata, user_word(user_answer));
		end
		finish_test("read_in_user_mode");

		// Bit 8 set releases the flash
		bus_request(1'b0, 1'b1, 1'b1, '0, 32'h100);
		if (lat != 1)
			value_error("leave user mode ack latency", lat, 1);
		if (spi.cs_n !== 1'b1)
			value_error("chip select after leaving user mode", spi.cs_n, 1);
		repeat (8)
		begin
			addr = $random(seed);
			check_mem_read(addr);
		end
		finish_test("leave_user_mode");

		errors += dut_i.ctrl_i.props_i.fail_count;
		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire
